// ==== hdl/matmul_pkg.sv ====
`default_nettype none

package matmul_pkg;

    localparam int MAT_N     = 4;
    localparam int OP_W      = 16;
    localparam int ACC_W     = 32;
    localparam int REG_ID_W  = 5;
    localparam int ROW_IDX_W = 2;

    // operand beats, then one output row per cycle
    localparam int LOAD_CYCLES  = 4;
    localparam int DRAIN_CYCLES = 4;

    localparam int STEP_W = $clog2(LOAD_CYCLES + DRAIN_CYCLES);

    // beat 0 comes with start, beats 1..3 are taken at steps 0..2
    localparam logic [STEP_W-1:0] LAST_LOAD_STEP = STEP_W'(LOAD_CYCLES - 2);
    localparam logic [STEP_W-1:0] DRAIN_START    = STEP_W'(LOAD_CYCLES);
    localparam logic [STEP_W-1:0] LAST_STEP      = STEP_W'(LOAD_CYCLES + DRAIN_CYCLES - 1);

    typedef logic signed [OP_W-1:0]  op_elem_t;
    typedef logic signed [ACC_W-1:0] acc_elem_t;

    // one column of A or one row of B
    typedef op_elem_t [MAT_N-1:0] op_vec_t;
    // one row of C
    typedef acc_elem_t [MAT_N-1:0] acc_row_t;

    typedef logic [MAT_N-1:0] lane_mask_t;

    typedef struct packed {
        lane_mask_t a_rows;
        lane_mask_t a_cols;
        lane_mask_t b_rows;
        lane_mask_t b_cols;
    } mask_set_t;

    typedef struct packed {
        logic [REG_ID_W-1:0] reg_id;
        logic                we;
    } dst_tag_t;

    typedef struct packed {
        logic                 valid;
        logic [REG_ID_W-1:0]  reg_id;
        logic [ROW_IDX_W-1:0] row;
        logic                 we;
        lane_mask_t           lane_mask;
    } wb_tag_t;

endpackage

`default_nettype wire

// ==== hdl/mac_pe.sv ====
`default_nettype none

module mac_pe (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                clear,
    input  logic                                acc_en,
    input  logic signed [matmul_pkg::OP_W-1:0]  a_elem,
    input  logic signed [matmul_pkg::OP_W-1:0]  b_elem,
    output logic signed [matmul_pkg::ACC_W-1:0] acc
);

    logic signed [matmul_pkg::ACC_W-1:0] product;

    // full 16x16 product fits in 32 bits, only the sum wraps
    assign product = a_elem * b_elem;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (acc_en) begin
            acc <= acc + product;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/matmul_array.sv ====
`default_nettype none

module matmul_array (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                start,
    input  matmul_pkg::op_vec_t                 a_col,
    input  matmul_pkg::op_vec_t                 b_row,
    input  matmul_pkg::mask_set_t               masks,
    output logic                                busy,
    output logic                                row_valid,
    output logic [matmul_pkg::ROW_IDX_W-1:0]    row_idx,
    output matmul_pkg::acc_row_t                c_row
);

    logic [matmul_pkg::STEP_W-1:0]    step;
    logic [matmul_pkg::STEP_W-1:0]    drain_off;
    logic [matmul_pkg::ROW_IDX_W-1:0] beat_idx;
    logic [matmul_pkg::ROW_IDX_W-1:0] drain_idx;
    logic                             loading;
    logic                             draining;
    logic                             beat_on;
    logic                             beat_en;

    matmul_pkg::mask_set_t masks_q;
    matmul_pkg::mask_set_t mask_src;
    matmul_pkg::op_vec_t   a_q;
    matmul_pkg::op_vec_t   b_q;
    matmul_pkg::acc_row_t  row_masked;
    matmul_pkg::acc_row_t  acc_mat [matmul_pkg::MAT_N];

    assign loading   = busy && (step <= matmul_pkg::LAST_LOAD_STEP);
    assign draining  = busy && (step >= matmul_pkg::DRAIN_START);
    assign drain_off = step - matmul_pkg::DRAIN_START;
    assign drain_idx = drain_off[matmul_pkg::ROW_IDX_W-1:0];

    // masks are still on the inputs during the accept cycle
    assign mask_src = start ? masks : masks_q;
    assign beat_idx = start ? '0 : matmul_pkg::ROW_IDX_W'(step + 1'b1);
    assign beat_on  = mask_src.a_cols[beat_idx] && mask_src.b_rows[beat_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            step      <= '0;
            beat_en   <= 1'b0;
            row_valid <= 1'b0;
            row_idx   <= '0;
        end else begin
            beat_en   <= (start || loading) && beat_on;
            row_valid <= draining;
            if (draining) begin
                row_idx <= drain_idx;
            end
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == matmul_pkg::LAST_STEP) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // operand beat register, the cells see beat k one edge later
    always_ff @(posedge clk) begin
        if (start) begin
            masks_q <= masks;
        end
        if (start || loading) begin
            a_q <= a_col;
            b_q <= b_row;
        end
        if (draining) begin
            c_row <= row_masked;
        end
    end

    for (genvar i = 0; i < matmul_pkg::MAT_N; i++) begin : g_row
        for (genvar j = 0; j < matmul_pkg::MAT_N; j++) begin : g_col
            mac_pe pe_i (
                .clk    (clk),
                .arst_n (arst_n),
                .clear  (start),
                .acc_en (beat_en),
                .a_elem (a_q[i]),
                .b_elem (b_q[j]),
                .acc    (acc_mat[i][j])
            );
        end
    end

    // zero masked rows of A and masked columns of B
    always_comb begin
        row_masked = '0;
        for (int j = 0; j < matmul_pkg::MAT_N; j++) begin
            if (masks_q.a_rows[drain_idx] && masks_q.b_cols[j]) begin
                row_masked[j] = acc_mat[drain_idx][j];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/wb_tag_ctrl.sv ====
`default_nettype none

module wb_tag_ctrl (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             accept,
    input  logic                             busy,
    input  logic                             squash,
    input  matmul_pkg::dst_tag_t             in_dst,
    input  matmul_pkg::lane_mask_t           vmask,
    input  matmul_pkg::mask_set_t            masks,
    input  logic                             row_valid,
    input  logic [matmul_pkg::ROW_IDX_W-1:0] row_idx,
    output matmul_pkg::wb_tag_t              wb
);

    matmul_pkg::dst_tag_t   dst_q;
    matmul_pkg::lane_mask_t lane_q;
    matmul_pkg::lane_mask_t a_rows_q;
    logic                   squashed;

    // busy is still high at the edge that shifts out the last row,
    // so a squash there reaches row 3 as well
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            squashed <= 1'b0;
        end else if (accept) begin
            squashed <= squash;
        end else if (busy && squash) begin
            squashed <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dst_q    <= in_dst;
            lane_q   <= vmask & masks.b_cols;
            a_rows_q <= masks.a_rows;
        end
    end

    always_comb begin
        wb           = '0;
        wb.valid     = row_valid;
        wb.reg_id    = dst_q.reg_id;
        wb.row       = row_idx;
        wb.lane_mask = lane_q;
        wb.we        = row_valid && dst_q.we && a_rows_q[row_idx] && !squashed;
    end

endmodule

`default_nettype wire

// ==== hdl/matmul_unit.sv ====
`default_nettype none

module matmul_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   activate,
    input  logic                   squash,
    input  matmul_pkg::op_vec_t    a_data,
    input  matmul_pkg::op_vec_t    b_data,
    input  matmul_pkg::mask_set_t  masks,
    input  matmul_pkg::lane_mask_t vmask,
    input  matmul_pkg::dst_tag_t   in_dst,
    output logic                   stall,
    output matmul_pkg::acc_row_t   c_row,
    output matmul_pkg::wb_tag_t    wb
);

    logic                             busy;
    logic                             accept;
    logic                             row_valid;
    logic [matmul_pkg::ROW_IDX_W-1:0] row_idx;

    // activate only counts while the engine is idle
    assign accept = activate && !busy;
    assign stall  = busy;

    matmul_array array_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (accept),
        .a_col     (a_data),
        .b_row     (b_data),
        .masks     (masks),
        .busy      (busy),
        .row_valid (row_valid),
        .row_idx   (row_idx),
        .c_row     (c_row)
    );

    wb_tag_ctrl tag_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .accept    (accept),
        .busy      (busy),
        .squash    (squash),
        .in_dst    (in_dst),
        .vmask     (vmask),
        .masks     (masks),
        .row_valid (row_valid),
        .row_idx   (row_idx),
        .wb        (wb)
    );

endmodule

`default_nettype wire

// ==== tests/matmul_unit_tb.sv ====
`default_nettype none

module matmul_unit_tb;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 4;
    localparam int MAX_TESTS       = 16;
    localparam int ROUNDS          = 2;
    localparam int CYCLES_PER_TEST = 16;
    localparam int TIMEOUT_MARGIN  = 20;
    localparam int N               = matmul_pkg::MAT_N;

    logic                   clk;
    logic                   arst_n;
    logic                   activate;
    logic                   squash;
    matmul_pkg::op_vec_t    a_data;
    matmul_pkg::op_vec_t    b_data;
    matmul_pkg::mask_set_t  masks;
    matmul_pkg::lane_mask_t vmask;
    matmul_pkg::dst_tag_t   in_dst;
    logic                   stall;
    matmul_pkg::acc_row_t   c_row;
    matmul_pkg::wb_tag_t    wb;

    // one record per test, A and B kept row by row
    matmul_pkg::mask_set_t  t_masks  [MAX_TESTS];
    matmul_pkg::lane_mask_t t_vmask  [MAX_TESTS];
    matmul_pkg::dst_tag_t   t_dst    [MAX_TESTS];
    int                     t_squash [MAX_TESTS];
    matmul_pkg::op_vec_t    t_a      [MAX_TESTS][N];
    matmul_pkg::op_vec_t    t_b      [MAX_TESTS][N];
    matmul_pkg::acc_row_t   t_c      [MAX_TESTS][N];

    int ntests;
    int cycles;
    int limit;
    int seed;
    int gap;

    matmul_unit dut_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .activate (activate),
        .squash   (squash),
        .a_data   (a_data),
        .b_data   (b_data),
        .masks    (masks),
        .vmask    (vmask),
        .in_dst   (in_dst),
        .stall    (stall),
        .c_row    (c_row),
        .wb       (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > limit) begin
            abort_run($sformatf("result rows never arrived within %0d cycles", limit));
        end
    endtask

    task automatic check_row(input string name, input matmul_pkg::acc_row_t exp,
                             input matmul_pkg::acc_row_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    // with no row expected only the valid bit is meaningful
    task automatic check_tag(input string name, input matmul_pkg::wb_tag_t exp,
                             input matmul_pkg::wb_tag_t act);
        logic bad;
        bad = exp.valid ? (act !== exp) : (act.valid !== 1'b0);
        if (bad) begin
            abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_stall(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic read_tests();
        int               fd;
        int               code;
        int               sq;
        logic [8*160-1:0] text;
        logic [31:0]      f [8];
        fd = $fopen("tests/matmul_unit_input.txt", "r");
        if (fd == 0) begin
            abort_run("could not open tests/matmul_unit_input.txt");
        end
        // two column description lines
        code = $fgets(text, fd);
        code = $fgets(text, fd);
        ntests = 0;
        code = $fscanf(fd, "%h %h %h %h %h %h %h %d", f[0], f[1], f[2], f[3], f[4], f[5],
                       f[6], sq);
        while (code == 8 && ntests < MAX_TESTS) begin
            t_masks[ntests].a_rows = f[0][N-1:0];
            t_masks[ntests].a_cols = f[1][N-1:0];
            t_masks[ntests].b_rows = f[2][N-1:0];
            t_masks[ntests].b_cols = f[3][N-1:0];
            t_vmask[ntests]        = f[4][N-1:0];
            t_dst[ntests].reg_id   = f[5][matmul_pkg::REG_ID_W-1:0];
            t_dst[ntests].we       = f[6][0];
            t_squash[ntests]       = sq;
            for (int i = 0; i < N; i++) begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4],
                               f[5], f[6], f[7]);
                if (code != 8) begin
                    abort_run("operand line in the data file is incomplete");
                end
                for (int j = 0; j < N; j++) begin
                    t_a[ntests][i][j] = f[j][matmul_pkg::OP_W-1:0];
                    t_b[ntests][i][j] = f[j+N][matmul_pkg::OP_W-1:0];
                end
            end
            for (int i = 0; i < N; i++) begin
                code = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
                if (code != 4) begin
                    abort_run("expected row in the data file is incomplete");
                end
                for (int j = 0; j < N; j++) begin
                    t_c[ntests][i][j] = f[j];
                end
            end
            ntests++;
            code = $fscanf(fd, "%h %h %h %h %h %h %h %d", f[0], f[1], f[2], f[3], f[4],
                           f[5], f[6], sq);
        end
        $fclose(fd);
        if (ntests == 0) begin
            abort_run("the data file holds no tests");
        end
    endtask

    // beat k: column k of A and row k of B
    task automatic drive_beat(input int t, input int k);
        for (int i = 0; i < N; i++) begin
            a_data[i] = t_a[t][i][k];
        end
        b_data = t_b[t][k];
    endtask

    // the unit must hold what it took at accept, so scramble the inputs
    task automatic drive_noise();
        logic [31:0] noise;
        noise  = $random(seed);
        a_data = {noise, noise ^ 32'h5a5a_a5a5};
        b_data = {noise[15:0], noise[31:16], ~noise};
        masks  = noise[15:0];
        vmask  = noise[19:16];
        in_dst = noise[25:20];
    endtask

    task automatic run_test(input int t, input logic keep_we);
        int                   e;
        int                   nrows;
        int                   sq;
        matmul_pkg::dst_tag_t dst;
        matmul_pkg::wb_tag_t  exp_tag;
        sq     = t_squash[t];
        dst    = t_dst[t];
        dst.we = dst.we && keep_we;
        while (stall) begin
            next_cycle();
        end
        drive_beat(t, 0);
        activate = 1'b1;
        squash   = (sq == 0);
        masks    = t_masks[t];
        vmask    = t_vmask[t];
        in_dst   = dst;
        next_cycle();
        e     = 0;
        nrows = 0;
        while (nrows < N) begin
            check_stall("stall", e < 8, stall);
            if (wb.valid) begin
                if (e != 5 + nrows) begin
                    abort_run($sformatf("row %0d showed up after edge %0d, not edge %0d",
                                        nrows, e, 5 + nrows));
                end
                exp_tag.valid     = 1'b1;
                exp_tag.reg_id    = dst.reg_id;
                exp_tag.row       = nrows[matmul_pkg::ROW_IDX_W-1:0];
                exp_tag.we        = dst.we && t_masks[t].a_rows[nrows]
                                    && !(sq >= 0 && sq <= 5 + nrows);
                exp_tag.lane_mask = t_vmask[t] & t_masks[t].b_cols;
                check_row($sformatf("c_row[%0d]", nrows), t_c[t][nrows], c_row);
                check_tag($sformatf("wb[%0d]", nrows), exp_tag, wb);
                nrows++;
            end
            if (nrows < N) begin
                drive_noise();
                if (e + 1 < matmul_pkg::LOAD_CYCLES) begin
                    drive_beat(t, e + 1);
                end
                // activate while stalled must be ignored
                activate = ($random(seed) % 2 != 0);
                squash   = (sq == e + 1);
                next_cycle();
                e++;
            end
        end
        activate = 1'b0;
        squash   = 1'b0;
    endtask

    initial begin
        seed     = 73;
        cycles   = 0;
        limit    = TIMEOUT_MARGIN;
        arst_n   = 1'b0;
        activate = 1'b0;
        squash   = 1'b0;
        a_data   = '0;
        b_data   = '0;
        masks    = '0;
        vmask    = '0;
        in_dst   = '0;
        read_tests();
        limit = CYCLES_PER_TEST * ROUNDS * ntests + TIMEOUT_MARGIN;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_stall("stall", 1'b0, stall);
        check_tag("wb", '0, wb);
        // second round runs every record again with in_dst.we low
        for (int r = 0; r < ROUNDS; r++) begin
            for (int t = 0; t < ntests; t++) begin
                // every odd test starts right as stall falls
                gap = (t % 2 == 1) ? 0 : {$random(seed)} % 4;
                repeat (gap) next_cycle();
                run_test(t, r == 0);
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/matmul_unit_input.txt ====
# header: a_rows a_cols b_rows b_cols vmask reg_id we squash_edge (-1 none), all hex but squash
# then 4 lines of A row i and B row i (4 + 4 elems), then 4 lines of expected C row i

f f f f f 03 1 -1
0001 0002 0003 0004  0001 0000 ffff 0002
ffff 0000 0002 fffd  0002 0001 0000 ffff
0005 fffe 0000 0001  0000 0003 0001 0001
0000 0001 ffff 0002  fffe 0001 0002 0000
fffffffd 0000000f 0000000a 00000003
00000005 00000003 fffffffd 00000000
ffffffff ffffffff fffffffd 0000000c
fffffffe 00000000 00000003 fffffffe

f f f f f 1f 1 0
8000 8000 8000 8000  8000 8000 8000 8000
8000 8000 8000 8000  8000 8000 8000 8000
8000 8000 8000 8000  8000 8000 8000 8000
8000 8000 8000 8000  0001 0001 0001 0001
bfff8000 bfff8000 bfff8000 bfff8000
bfff8000 bfff8000 bfff8000 bfff8000
bfff8000 bfff8000 bfff8000 bfff8000
bfff8000 bfff8000 bfff8000 bfff8000

f b e f f 07 1 -1
0001 0002 0003 0004  0001 0000 ffff 0002
ffff 0000 0002 fffd  0002 0001 0000 ffff
0005 fffe 0000 0001  0000 0003 0001 0001
0000 0001 ffff 0002  fffe 0001 0002 0000
fffffffc 00000006 00000008 fffffffe
00000006 fffffffd fffffffa 00000000
fffffffa ffffffff 00000002 00000002
fffffffe 00000003 00000004 ffffffff

5 f f 6 c 0a 1 -1
0001 0001 0001 0001  000a 0014 001e 0028
0002 0002 0002 0002  0001 0002 0003 0004
0003 0000 0000 0000  0100 0200 0300 0400
0004 0004 0004 0004  ffff ffff ffff ffff
00000000 00000215 00000320 00000000
00000000 00000000 00000000 00000000
00000000 0000003c 0000005a 00000000
00000000 00000000 00000000 00000000

f f f f 3 12 1 6
0001 0002 0003 0004  0001 0000 ffff 0002
ffff 0000 0002 fffd  0002 0001 0000 ffff
0005 fffe 0000 0001  0000 0003 0001 0001
0000 0001 ffff 0002  fffe 0001 0002 0000
fffffffd 0000000f 0000000a 00000003
00000005 00000003 fffffffd 00000000
ffffffff ffffffff fffffffd 0000000c
fffffffe 00000000 00000003 fffffffe

f f f f f 05 1 8
0001 0000 0000 0000  7fff 8000 0001 ffff
0000 0001 0000 0000  1234 edcb 0000 0010
0000 0000 0001 0000  0002 0003 0004 0005
0000 0000 0000 0001  ffff fffe fffd fffc
00007fff ffff8000 00000001 ffffffff
00001234 ffffedcb 00000000 00000010
00000002 00000003 00000004 00000005
ffffffff fffffffe fffffffd fffffffc

// ==== verilog.f ====
hdl/matmul_pkg.sv
hdl/mac_pe.sv
hdl/matmul_array.sv
hdl/wb_tag_ctrl.sv
hdl/matmul_unit.sv
tests/matmul_unit_tb.sv

// ==== Bender.yml ====
package:
  name: matmul_unit

sources:
  - hdl/matmul_pkg.sv
  - hdl/mac_pe.sv
  - hdl/matmul_array.sv
  - hdl/wb_tag_ctrl.sv
  - hdl/matmul_unit.sv
  - target: test
    files:
      - tests/matmul_unit_tb.sv
